//--- source/ks_adder_params.svh
//----------------------------------------------------------
// width and prefix depth for the Kogge-Stone adder
//----------------------------------------------------------

`ifndef KS_ADDER_PARAMS_SVH
`define KS_ADDER_PARAMS_SVH

// operand width in bits
`define KS_WIDTH 32

// prefix levels, log2 of the width
// must track KS_WIDTH, the tree spans 2**KS_LEVELS bits
`define KS_LEVELS 5

`endif

//--- source/ks_adder_pkg.sv
//----------------------------------------------------------
// adder types
//   operand word
//   bitwise generate / propagate / half-sum bundle
//   registered sum with carry-out
//----------------------------------------------------------

`include "ks_adder_params.svh"

package ks_adder_pkg;

	// one input operand
	typedef logic [`KS_WIDTH-1:0] operand_t;

	//----------------------------------------------------------
	// bitwise terms from the operand stage
	//----------------------------------------------------------
	typedef struct packed {
		// a and b, carry made at this bit
		logic [`KS_WIDTH-1:0] gen;
		// a or b, inclusive propagate
		logic [`KS_WIDTH-1:0] prop;
		// a xor b, sum before the incoming carry
		logic [`KS_WIDTH-1:0] half_sum;
	} pg_vec_t;

	//----------------------------------------------------------
	// adder output
	//----------------------------------------------------------
	// carry_out sits above sum so the struct reads as the full
	// KS_WIDTH+1 bit sum
	typedef struct packed {
		logic                 carry_out;
		logic [`KS_WIDTH-1:0] sum;
	} sum_result_t;

endpackage

//--- source/ks_pg_stage.sv
//----------------------------------------------------------
// operand stage
//   bitwise generate, propagate and half-sum
//   registered together with the valid strobe
//----------------------------------------------------------

`timescale 1ns/1ps

module ks_pg_stage
	import ks_adder_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     in_valid,
	input  operand_t a,
	input  operand_t b,
	output pg_vec_t  pg,
	output logic     pg_valid
);

	pg_vec_t pg_next;

	//----------------------------------------------------------
	// bitwise terms
	//----------------------------------------------------------
	always_comb begin
		// carry generated here when both bits are set
		pg_next.gen = a & b;
		// an incoming carry passes on when either bit is set
		pg_next.prop = a | b;
		// sum bit ignoring the incoming carry
		pg_next.half_sum = a ^ b;
	end

	//----------------------------------------------------------
	// stage registers
	//----------------------------------------------------------
	// payload only moves on accepted operands
	always_ff @(posedge clk) begin
		if (in_valid) begin
			pg <= pg_next;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pg_valid <= 1'b0;
		end else begin
			pg_valid <= in_valid;
		end
	end

	//----------------------------------------------------------
	// checks
	//----------------------------------------------------------
	// the prefix tree's group terms rely on g implying p
	// or a generate could be masked by a low propagate
	// in the combine cell downstream
	a_gen_implies_prop : assert property (
		@(posedge clk) disable iff (rst)
		pg_valid |-> ((pg.gen & ~pg.prop) == '0)
	) else $error("generate bit set without its propagate bit");

endmodule

//--- source/ks_prefix_tree.sv
//----------------------------------------------------------
// Kogge-Stone prefix network
//   log2(width) levels of group generate/propagate cells
//   carry out of every bit, carry-in fixed at zero
//----------------------------------------------------------

`timescale 1ns/1ps

`include "ks_adder_params.svh"

module ks_prefix_tree
	import ks_adder_pkg::*;
(
	input  pg_vec_t  pg,
	output operand_t carries
);

	// level 0 is the bitwise terms, level k+1 the output of level k
	// g_lvl[k][i] covers bits i down to max(0, i - 2**k + 1)
	logic [`KS_LEVELS:0][`KS_WIDTH-1:0]   g_lvl;
	// last level's group propagates are never read, so stop one short
	logic [`KS_LEVELS-1:0][`KS_WIDTH-1:0] p_lvl;

	assign g_lvl[0] = pg.gen;
	assign p_lvl[0] = pg.prop;

	//----------------------------------------------------------
	// prefix levels
	//----------------------------------------------------------
	for (genvar k = 0; k < `KS_LEVELS; k++) begin : g_level
		// distance to the low partner at this level
		localparam int SPAN = 1 << k;

		for (genvar i = 0; i < `KS_WIDTH; i++) begin : g_node
			if (i >= SPAN) begin : g_combine
				// high group absorbs the adjacent low group
				// G = Gh | (Ph & Gl)
				assign g_lvl[k+1][i] = g_lvl[k][i] |
					(p_lvl[k][i] & g_lvl[k][i-SPAN]);

				if (k < `KS_LEVELS - 1) begin : g_prop
					// P = Ph & Pl
					assign p_lvl[k+1][i] = p_lvl[k][i] & p_lvl[k][i-SPAN];
				end
			end else begin : g_pass
				// group already reaches bit 0, nothing below to add
				assign g_lvl[k+1][i] = g_lvl[k][i];

				if (k < `KS_LEVELS - 1) begin : g_prop
					assign p_lvl[k+1][i] = p_lvl[k][i];
				end
			end
		end
	end

	//----------------------------------------------------------
	// carries
	//----------------------------------------------------------
	// every group now spans down to bit 0; with no carry-in its
	// generate is the carry out of that bit
	assign carries = g_lvl[`KS_LEVELS];

endmodule

//--- source/ks_sum_stage.sv
//----------------------------------------------------------
// sum stage
//   half-sums combined with carries from the prefix tree
//   registered sum, carry-out and valid
//----------------------------------------------------------

`timescale 1ns/1ps

`include "ks_adder_params.svh"

module ks_sum_stage
	import ks_adder_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        pg_valid,
	input  pg_vec_t     pg,
	input  operand_t    carries,
	output sum_result_t result,
	output logic        out_valid
);

	sum_result_t result_next;

	//----------------------------------------------------------
	// sum formation
	//----------------------------------------------------------
	always_comb begin
		// bit i takes the carry out of bit i-1
		// bit 0 sees the zero carry-in
		result_next.sum = pg.half_sum ^ {carries[`KS_WIDTH-2:0], 1'b0};
		result_next.carry_out = carries[`KS_WIDTH-1];
	end

	//----------------------------------------------------------
	// output registers
	//----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (pg_valid) begin
			result <= result_next;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= pg_valid;
		end
	end

	//----------------------------------------------------------
	// checks
	//----------------------------------------------------------
	// one output pulse per pair leaving the operand stage
	a_valid_tracks_pg : assert property (
		@(posedge clk)
		!rst |=> (out_valid == $past(pg_valid))
	) else $error("out_valid does not follow pg_valid");

	// nothing comes out right after a reset cycle
	a_valid_low_after_rst : assert property (
		@(posedge clk)
		rst |=> !out_valid
	) else $error("out_valid high after reset");

endmodule

//--- source/ks_adder_top.sv
//----------------------------------------------------------
// pipelined 32-bit Kogge-Stone adder, latency 2
//   operand stage, prefix tree, sum stage
//----------------------------------------------------------

`timescale 1ns/1ps

module ks_adder_top
	import ks_adder_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        in_valid,
	input  operand_t    a,
	input  operand_t    b,
	output logic        out_valid,
	output sum_result_t result
);

	// stage 1 to stage 2
	pg_vec_t  pg;
	logic     pg_valid;
	// tree output, combinational in the second cycle
	operand_t carries;

	//----------------------------------------------------------
	// cycle 1 bitwise terms
	//----------------------------------------------------------
	ks_pg_stage i_pg_stage (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.a        (a),
		.b        (b),
		.pg       (pg),
		.pg_valid (pg_valid)
	);

	//----------------------------------------------------------
	// cycle 2 carries and sum
	//----------------------------------------------------------
	ks_prefix_tree i_prefix_tree (
		.pg      (pg),
		.carries (carries)
	);

	ks_sum_stage i_sum_stage (
		.clk       (clk),
		.rst       (rst),
		.pg_valid  (pg_valid),
		.pg        (pg),
		.carries   (carries),
		.result    (result),
		.out_valid (out_valid)
	);

endmodule

//--- verif/ks_adder_tb.sv
//----------------------------------------------------------
// testbench for the pipelined Kogge-Stone adder
//   clock, reset, xorshift stimulus, 33-bit sum model
//   compare tasks, cycle limit and closing summary
//----------------------------------------------------------

`timescale 1ns/1ps

`include "ks_adder_params.svh"

module ks_adder_tb
	import ks_adder_pkg::*;
();

	localparam int RST_CYCLES  = 4;
	localparam int IDLE_CYCLES = 6;
	localparam int N_RANDOM    = 1000;
	localparam int N_CORNER    = 4 + 2 * `KS_WIDTH;
	localparam int N_GAP       = 600;
	localparam int N_FLAG      = 400;
	localparam int DRAIN       = 4;
	localparam int LATENCY     = 2;
	localparam int MAX_CYCLES  = RST_CYCLES + IDLE_CYCLES + N_RANDOM + N_CORNER + N_GAP
		+ N_FLAG + DRAIN + LATENCY + 20;

	logic        clk;
	logic        rst;
	logic        in_valid;
	operand_t    a;
	operand_t    b;
	logic        out_valid;
	sum_result_t result;

	// 0 no flag check, 1 carry_out must be high, 2 must be low
	int          flag_mode;
	logic [31:0] rng_state;
	int          cycle_count;
	int          value_errors;
	int          protocol_errors;
	int          in_count;
	int          out_count;

	// model queues with one entry per accepted pair
	sum_result_t exp_q[$];
	int          stamp_q[$];
	int          flag_q[$];

	ks_adder_top i_ks_adder_top (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.a         (a),
		.b         (b),
		.out_valid (out_valid),
		.result    (result)
	);

	always #50 clk = ~clk;

	//----------------------------------------------------------
	// random numbers and driving
	//----------------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic next_rand(output operand_t r);
		rng_state = xorshift32(rng_state);
		r = rng_state;
	endtask

	task automatic drive_pair(input logic v, input operand_t x, input operand_t y,
			input int flag);
		@(posedge clk);
		in_valid  <= v;
		a         <= x;
		b         <= y;
		flag_mode <= flag;
	endtask

	//----------------------------------------------------------
	// compare tasks
	//----------------------------------------------------------
	task automatic check_result(input sum_result_t got, input sum_result_t exp);
		if (got !== exp) begin
			$display("Error at %0t: result carry_out=%b sum=%h, expected carry_out=%b sum=%h",
				$time, got.carry_out, got.sum, exp.carry_out, exp.sum);
			value_errors++;
		end
	endtask

	task automatic check_carry(input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error at %0t: carry_out flag %b, expected %b", $time, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_valid(input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error at %0t: out_valid %b, expected %b", $time, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_count(input int got, input int exp);
		if (got != exp) begin
			$display("Error at %0t: %0d outputs for %0d accepted pairs", $time, got, exp);
			value_errors++;
		end
	endtask

	//----------------------------------------------------------
	// model and output monitor
	//----------------------------------------------------------
	always @(posedge clk) begin : monitor
		sum_result_t          exp;
		logic [`KS_WIDTH:0]   full;
		int                   stamp;
		int                   flag;

		cycle_count <= cycle_count + 1;
		if (!rst && out_valid) begin
			out_count++;
			if (exp_q.size() == 0) begin
				$display("Output seen at %0t with no accepted pair waiting for it", $time);
				protocol_errors++;
			end else begin
				exp   = exp_q.pop_front();
				stamp = stamp_q.pop_front();
				flag  = flag_q.pop_front();
				check_result(result, exp);
				if (flag != 0)
					check_carry(result.carry_out, flag == 1);
				// stamped at the sampling edge, visible here two edges later
				if (cycle_count - stamp != LATENCY) begin
					$display("Error at %0t: output came %0d edges after its input",
						$time, cycle_count - stamp);
					value_errors++;
				end
			end
		end
		if (!rst && in_valid) begin
			in_count++;
			full = {1'b0, a} + {1'b0, b};
			exp.carry_out = full[`KS_WIDTH];
			exp.sum = full[`KS_WIDTH-1:0];
			exp_q.push_back(exp);
			stamp_q.push_back(cycle_count);
			flag_q.push_back(flag_mode);
		end
	end

	// cycle limit
	always @(posedge clk) begin
		if (cycle_count >= MAX_CYCLES) begin
			$display("Run stopped: limit of %0d cycles reached, %0d results still missing",
				MAX_CYCLES, exp_q.size());
			$display("Simulation failed");
			$finish;
		end
	end

	//----------------------------------------------------------
	// stimulus
	//----------------------------------------------------------
	initial begin
		operand_t x;
		operand_t y;
		operand_t bit_i;
		logic     v;

		clk = 1'b0;
		rst = 1'b1;
		in_valid = 1'b0;
		a = '0;
		b = '0;
		flag_mode = 0;
		rng_state = 32'd42;
		cycle_count = 0;
		value_errors = 0;
		protocol_errors = 0;
		in_count = 0;
		out_count = 0;

		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;

		// quiet pipeline after reset
		repeat (IDLE_CYCLES) begin
			@(posedge clk);
			check_valid(out_valid, 1'b0);
		end

		// back-to-back random pairs
		for (int n = 0; n < N_RANDOM; n++) begin
			next_rand(x);
			next_rand(y);
			drive_pair(1'b1, x, y, 0);
		end

		// carry chains through every prefix level
		drive_pair(1'b1, '1, operand_t'(1), 0);
		drive_pair(1'b1, '1, '1, 0);
		drive_pair(1'b1, '0, '0, 0);
		drive_pair(1'b1, operand_t'(1) << (`KS_WIDTH - 1),
			operand_t'(1) << (`KS_WIDTH - 1), 0);
		for (int i = 0; i < `KS_WIDTH; i++) begin
			bit_i = operand_t'(1) << i;
			// chain from bit i up to carry_out
			drive_pair(1'b1, bit_i, ~(bit_i - 1), 0);
			// chain from bit 0 up to bit i
			drive_pair(1'b1, bit_i - 1, operand_t'(1), 0);
		end

		// valid low about a third of the time
		for (int n = 0; n < N_GAP; n++) begin
			next_rand(x);
			next_rand(y);
			v = (rng_state % 3) != 0;
			drive_pair(v, x, y, 0);
		end

		// carry_out flag with top bits both set then both clear
		for (int n = 0; n < N_FLAG / 2; n++) begin
			next_rand(x);
			next_rand(y);
			drive_pair(1'b1, x | (operand_t'(1) << (`KS_WIDTH - 1)),
				y | (operand_t'(1) << (`KS_WIDTH - 1)), 1);
		end
		for (int n = 0; n < N_FLAG / 2; n++) begin
			next_rand(x);
			next_rand(y);
			drive_pair(1'b1, x & 32'h0fff_ffff, y & 32'h0fff_ffff, 2);
		end

		drive_pair(1'b0, '0, '0, 0);
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (DRAIN) @(posedge clk);

		check_count(out_count, in_count);
		if (exp_q.size() != 0) begin
			$display("%0d expected results were never produced", exp_q.size());
			protocol_errors++;
		end

		$display("value errors %0d, protocol errors %0d, pairs in %0d, results out %0d",
			value_errors, protocol_errors, in_count, out_count);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- sources.f
+incdir+source
source/ks_adder_pkg.sv
source/ks_pg_stage.sv
source/ks_prefix_tree.sv
source/ks_sum_stage.sv
source/ks_adder_top.sv
verif/ks_adder_tb.sv
